/* design/l2_cache_config.svh */
// L2 cache geometry
// Ways, sets, line width and line address width shared by all blocks

`ifndef L2_CACHE_CONFIG_SVH
`define L2_CACHE_CONFIG_SVH

// Associativity and number of sets
`define L2_WAYS 4
`define L2_SETS 16

// One line of data, addressed by line
`define L2_LINE_BITS 64
`define L2_ADDR_BITS 12

`endif

/* design/l2_cache_pkg.sv */
// L2 cache types
// Index, tag and line types, the line address union and the stage packet

`default_nettype none

`include "l2_cache_config.svh"

package l2_cache_pkg;
	typedef logic [$clog2(`L2_SETS) - 1:0] l2_set_idx_t;
	typedef logic [$clog2(`L2_WAYS) - 1:0] l2_way_idx_t;
	typedef logic [`L2_ADDR_BITS - $clog2(`L2_SETS) - 1:0] l2_tag_t;
	typedef logic [`L2_LINE_BITS - 1:0] l2_line_t;

	// Line address, either one word or tag above set index
	typedef union packed {
		logic [`L2_ADDR_BITS - 1:0] l2_addr_word;
		struct packed {
			l2_tag_t tag;
			l2_set_idx_t set_idx;
		} fields;
	} l2_addr_t;

	typedef enum logic {
		op_load = 1'b0,
		op_store = 1'b1
	} l2_op_t;

	// Carried from arbiter through the tag stage
	typedef struct packed {
		logic valid;
		logic is_fill;
		l2_op_t op;
		l2_addr_t address;
		l2_line_t data;
	} l2_packet_t;
endpackage

`default_nettype wire

/* design/l2_cache_if.sv */
// L2 cache internal buses
// Tag/dirty update bus from the control stage and lookup result bus
// from the tag stage

`default_nettype none

`include "l2_cache_config.svh"

interface l2_update_if;
	import l2_cache_pkg::*;

	// Tag and valid write, one enable per way
	logic [`L2_WAYS - 1:0] tag_en;
	l2_set_idx_t tag_set;
	logic tag_valid;
	l2_tag_t tag_value;

	// Dirty bit write
	logic [`L2_WAYS - 1:0] dirty_en;
	l2_set_idx_t dirty_set;
	logic dirty_value;

	modport read_side(output tag_en, tag_set, tag_valid, tag_value,
		dirty_en, dirty_set, dirty_value);
	modport tag_side(input tag_en, tag_set, tag_valid, tag_value,
		dirty_en, dirty_set, dirty_value);
endinterface

interface l2_lookup_if;
	import l2_cache_pkg::*;

	l2_packet_t packet;

	// Per way state of the looked up set
	logic [`L2_WAYS - 1:0] way_valid;
	l2_tag_t [`L2_WAYS - 1:0] way_tag;
	logic [`L2_WAYS - 1:0] way_dirty;

	modport tag_side(output packet, way_valid, way_tag, way_dirty);
	modport read_side(input packet, way_valid, way_tag, way_dirty);
endinterface

`default_nettype wire

/* design/sram_1r1w.sv */
// One read, one write synchronous memory
// Registered read; a same-address write in the same cycle is bypassed

`default_nettype none

module sram_1r1w #(
	parameter DATA_WIDTH = 32,
	parameter SIZE = 64,
	localparam ADDR_WIDTH = $clog2(SIZE)
)(
	input wire clk,
	input wire read_en,
	input wire [ADDR_WIDTH - 1:0] read_addr,
	output logic [DATA_WIDTH - 1:0] read_data,
	input wire write_en,
	input wire [ADDR_WIDTH - 1:0] write_addr,
	input wire [DATA_WIDTH - 1:0] write_data);

	logic [DATA_WIDTH - 1:0] mem[SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;

		if (read_en)
		begin
			// New data wins on collision
			if (write_en && write_addr == read_addr)
				read_data <= write_data;
			else
				read_data <= mem[read_addr];
		end
	end

	assert property (@(posedge clk)
		read_en |-> !$isunknown(read_addr) && read_addr < SIZE)
		else $error("sram read address out of range");
	assert property (@(posedge clk)
		write_en |-> !$isunknown(write_addr) && write_addr < SIZE)
		else $error("sram write address out of range");
endmodule

`default_nettype wire

/* design/cache_lru.sv */
// True LRU per set
// Keeps a recency order per set, gives the least recent way of the
// addressed set and moves an updated way to most recent

`default_nettype none

`include "l2_cache_config.svh"

module cache_lru(
	input wire clk,
	input wire reset,
	input wire l2_cache_pkg::l2_set_idx_t set,
	output l2_cache_pkg::l2_way_idx_t victim_way,
	input wire update_en,
	input wire l2_cache_pkg::l2_way_idx_t update_way);

	import l2_cache_pkg::*;

	// Entry 0 is least recent, last entry most recent
	l2_way_idx_t [`L2_WAYS - 1:0] order[`L2_SETS];
	l2_way_idx_t [`L2_WAYS - 1:0] next_order;
	logic shifting;

	function automatic logic is_permutation(l2_way_idx_t [`L2_WAYS - 1:0] ord);
		logic [`L2_WAYS - 1:0] seen;
		seen = '0;
		for (int i = 0; i < `L2_WAYS; i++)
			seen[ord[i]] = 1'b1;
		return &seen;
	endfunction

	assign victim_way = order[set][0];

	// Drop update_way from its slot, close the gap, append it at the top
	always_comb
	begin
		next_order = order[set];
		shifting = 1'b0;
		for (int i = 0; i < `L2_WAYS - 1; i++)
		begin
			if (order[set][i] == update_way)
				shifting = 1'b1;
			if (shifting)
				next_order[i] = order[set][i + 1];
		end
		next_order[`L2_WAYS - 1] = update_way;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Way 0 least recent up to the last way
			for (int s = 0; s < `L2_SETS; s++)
				for (int w = 0; w < `L2_WAYS; w++)
					order[s][w] <= l2_way_idx_t'(w);
		end
		else if (update_en)
			order[set] <= next_order;
	end

	assert property (@(posedge clk) disable iff (reset)
		update_en |=> is_permutation(order[$past(set)]))
		else $error("LRU order lost a way");
endmodule

`default_nettype wire

/* design/l2_cache_arb.sv */
// L2 cache arbiter
// Fills win over requests; a colliding request waits one cycle in a
// hold register while busy is raised. The winner is registered

`default_nettype none

`include "l2_cache_config.svh"

module l2_cache_arb(
	input wire clk,
	input wire reset,
	input wire request_valid,
	input wire l2_cache_pkg::l2_op_t request_op,
	input wire [`L2_ADDR_BITS - 1:0] request_address,
	input wire l2_cache_pkg::l2_line_t request_data,
	input wire fill_valid,
	input wire [`L2_ADDR_BITS - 1:0] fill_address,
	input wire l2_cache_pkg::l2_line_t fill_data,
	output logic busy,
	output l2_cache_pkg::l2_packet_t packet);

	import l2_cache_pkg::*;

	logic hold_valid;
	l2_op_t hold_op;
	logic [`L2_ADDR_BITS - 1:0] hold_address;
	l2_line_t hold_data;
	l2_packet_t next_packet;

	assign busy = hold_valid;

	// Fill first, then a held request, then a fresh one
	always_comb
	begin
		next_packet = '0;
		if (fill_valid)
		begin
			next_packet.valid = 1'b1;
			next_packet.is_fill = 1'b1;
			next_packet.address.l2_addr_word = fill_address;
			next_packet.data = fill_data;
		end
		else if (hold_valid)
		begin
			next_packet.valid = 1'b1;
			next_packet.op = hold_op;
			next_packet.address.l2_addr_word = hold_address;
			next_packet.data = hold_data;
		end
		else if (request_valid)
		begin
			next_packet.valid = 1'b1;
			next_packet.op = request_op;
			next_packet.address.l2_addr_word = request_address;
			next_packet.data = request_data;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			hold_valid <= 1'b0;
			packet <= '0;
		end
		else
		begin
			packet <= next_packet;
			// Held request stays parked while fills keep arriving
			if (fill_valid && request_valid)
				hold_valid <= 1'b1;
			else if (!fill_valid)
				hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_valid && request_valid)
		begin
			hold_op <= request_op;
			hold_address <= request_address;
			hold_data <= request_data;
		end
	end

	assert property (@(posedge clk) disable iff (reset) request_valid |-> !busy)
		else $error("request presented while arbiter busy");
endmodule

`default_nettype wire

/* design/l2_cache_tag.sv */
// L2 cache tag stage
// Reads tag, dirty and valid state of every way for the packet's set.
// Updates from the control stage in the same cycle are bypassed, so the
// result is valid one cycle later together with the packet

`default_nettype none

`include "l2_cache_config.svh"

module l2_cache_tag(
	input wire clk,
	input wire reset,
	input wire l2_cache_pkg::l2_packet_t packet,
	l2_update_if.tag_side update,
	l2_lookup_if.tag_side lookup);

	import l2_cache_pkg::*;

	l2_set_idx_t lookup_set;

	// Valid flags live in registers so reset clears every line
	logic [`L2_WAYS - 1:0] line_valid[`L2_SETS];

	assign lookup_set = packet.address.fields.set_idx;

	genvar way;
	generate
		for (way = 0; way < `L2_WAYS; way++)
		begin : way_gen
			// Tag array for this way, bypass handled inside the RAM
			sram_1r1w #(.DATA_WIDTH($bits(l2_tag_t)), .SIZE(`L2_SETS)) i_tag_ram(
				.clk(clk),
				.read_en(packet.valid),
				.read_addr(lookup_set),
				.read_data(lookup.way_tag[way]),
				.write_en(update.tag_en[way]),
				.write_addr(update.tag_set),
				.write_data(update.tag_value));

			// Dirty bits for this way
			sram_1r1w #(.DATA_WIDTH(1), .SIZE(`L2_SETS)) i_dirty_ram(
				.clk(clk),
				.read_en(packet.valid),
				.read_addr(lookup_set),
				.read_data(lookup.way_dirty[way]),
				.write_en(update.dirty_en[way]),
				.write_addr(update.dirty_set),
				.write_data(update.dirty_value));
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < `L2_SETS; s++)
				line_valid[s] <= '0;
			lookup.way_valid <= '0;
		end
		else
		begin
			for (int w = 0; w < `L2_WAYS; w++)
			begin
				if (packet.valid)
				begin
					// Same-set update this cycle overrides the stored flag
					if (update.tag_en[w] && update.tag_set == lookup_set)
						lookup.way_valid[w] <= update.tag_valid;
					else
						lookup.way_valid[w] <= line_valid[lookup_set][w];
				end

				if (update.tag_en[w])
					line_valid[update.tag_set][w] <= update.tag_valid;
			end
		end
	end

	// Packet travels alongside its lookup result
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			lookup.packet <= '0;
		else
			lookup.packet <= packet;
	end
endmodule

`default_nettype wire

/* design/l2_cache_read.sv */
// L2 cache control stage
// Detects hits, writes tag, dirty, LRU and line data, and registers the
// response and eviction report. Line data comes straight from the data
// array's registered read

`default_nettype none

`include "l2_cache_config.svh"

module l2_cache_read(
	input wire clk,
	input wire reset,
	l2_lookup_if.read_side lookup,
	l2_update_if.read_side update,
	output logic response_valid,
	output logic response_hit,
	output l2_cache_pkg::l2_op_t response_op,
	output logic [`L2_ADDR_BITS - 1:0] response_address,
	output l2_cache_pkg::l2_line_t response_data,
	output logic evict_valid,
	output logic [`L2_ADDR_BITS - 1:0] evict_address);

	import l2_cache_pkg::*;

	l2_set_idx_t set;
	l2_tag_t tag;
	logic [`L2_WAYS - 1:0] hit_oh;
	logic [`L2_WAYS - 1:0] victim_oh;
	l2_way_idx_t hit_way;
	l2_way_idx_t victim_way;
	logic is_request;
	logic is_fill;
	logic hit;
	logic store_hit;
	l2_addr_t victim_addr;

	assign set = lookup.packet.address.fields.set_idx;
	assign tag = lookup.packet.address.fields.tag;
	assign is_request = lookup.packet.valid && !lookup.packet.is_fill;
	assign is_fill = lookup.packet.valid && lookup.packet.is_fill;

	// Tag compare against every valid way
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < `L2_WAYS; w++)
		begin
			hit_oh[w] = lookup.way_valid[w] && lookup.way_tag[w] == tag;
			if (hit_oh[w])
				hit_way = l2_way_idx_t'(w);
		end
	end

	assign hit = is_request && |hit_oh;
	assign store_hit = hit && lookup.packet.op == op_store;
	assign victim_oh = `L2_WAYS'(1) << victim_way;

	cache_lru i_lru(
		.clk(clk),
		.reset(reset),
		.set(set),
		.victim_way(victim_way),
		.update_en(hit || is_fill),
		.update_way(is_fill ? victim_way : hit_way));

	// Data array indexed by {way, set}; read and write share this cycle
	sram_1r1w #(.DATA_WIDTH(`L2_LINE_BITS), .SIZE(`L2_WAYS * `L2_SETS)) i_data_ram(
		.clk(clk),
		.read_en(is_request),
		.read_addr({hit_way, set}),
		.read_data(response_data),
		.write_en(store_hit || is_fill),
		.write_addr({is_fill ? victim_way : hit_way, set}),
		.write_data(lookup.packet.data));

	// Fill installs a valid tag in the victim way
	assign update.tag_en = is_fill ? victim_oh : '0;
	assign update.tag_set = set;
	assign update.tag_valid = 1'b1;
	assign update.tag_value = tag;

	// Store hit marks dirty, fill leaves the victim clean
	assign update.dirty_en = is_fill ? victim_oh : (store_hit ? hit_oh : '0);
	assign update.dirty_set = set;
	assign update.dirty_value = !is_fill;

	// Rebuild the victim's line address from its tag and this set
	always_comb
	begin
		victim_addr.fields.tag = lookup.way_tag[victim_way];
		victim_addr.fields.set_idx = set;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			response_valid <= 1'b0;
			evict_valid <= 1'b0;
		end
		else
		begin
			response_valid <= is_request;
			evict_valid <= is_fill && lookup.way_valid[victim_way]
				&& lookup.way_dirty[victim_way];
		end
	end

	always_ff @(posedge clk)
	begin
		response_hit <= hit;
		response_op <= lookup.packet.op;
		response_address <= lookup.packet.address.l2_addr_word;
		evict_address <= victim_addr.l2_addr_word;
	end

	// Fills only go to the victim, so a line never sits in two ways
	assert property (@(posedge clk) disable iff (reset) is_request |-> $onehot0(hit_oh))
		else $error("more than one way hit");
endmodule

`default_nettype wire

/* design/l2_cache_top.sv */
// L2 cache pipeline top level
// Arbiter, tag stage and control stage joined by the internal buses

`default_nettype none

`include "l2_cache_config.svh"

module l2_cache_top(
	input wire clk,
	input wire reset,
	input wire request_valid,
	input wire l2_cache_pkg::l2_op_t request_op,
	input wire [`L2_ADDR_BITS - 1:0] request_address,
	input wire [`L2_LINE_BITS - 1:0] request_data,
	input wire fill_valid,
	input wire [`L2_ADDR_BITS - 1:0] fill_address,
	input wire [`L2_LINE_BITS - 1:0] fill_data,
	output logic busy,
	output logic response_valid,
	output logic response_hit,
	output l2_cache_pkg::l2_op_t response_op,
	output logic [`L2_ADDR_BITS - 1:0] response_address,
	output logic [`L2_LINE_BITS - 1:0] response_data,
	output logic evict_valid,
	output logic [`L2_ADDR_BITS - 1:0] evict_address);

	import l2_cache_pkg::*;

	l2_packet_t arb_packet;

	l2_update_if update_bus();
	l2_lookup_if lookup_bus();

	l2_cache_arb i_arb(
		.clk(clk),
		.reset(reset),
		.request_valid(request_valid),
		.request_op(request_op),
		.request_address(request_address),
		.request_data(request_data),
		.fill_valid(fill_valid),
		.fill_address(fill_address),
		.fill_data(fill_data),
		.busy(busy),
		.packet(arb_packet));

	l2_cache_tag i_tag(
		.clk(clk),
		.reset(reset),
		.packet(arb_packet),
		.update(update_bus.tag_side),
		.lookup(lookup_bus.tag_side));

	l2_cache_read i_read(
		.clk(clk),
		.reset(reset),
		.lookup(lookup_bus.read_side),
		.update(update_bus.read_side),
		.response_valid(response_valid),
		.response_hit(response_hit),
		.response_op(response_op),
		.response_address(response_address),
		.response_data(response_data),
		.evict_valid(evict_valid),
		.evict_address(evict_address));
endmodule

`default_nettype wire

/* bench/l2_cache_tb.sv */
// L2 cache testbench
// Directed and random loads, stores and fills against a reference cache
// model with true LRU, checked in order and on time at the outputs

`default_nettype none

`include "l2_cache_config.svh"

module l2_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import l2_cache_pkg::*;

	typedef logic [`L2_ADDR_BITS - 1:0] addr_word_t;

	// One expected output event, due in a given cycle
	typedef struct packed {
		logic is_evict;
		logic hit;
		logic op;
		logic check_data;
		addr_word_t address;
		l2_line_t data;
		logic [31:0] due;
	} expect_t;

	localparam int NUM_RANDOM = 200;
	localparam int POOL_SIZE = 12;

	logic clk;
	logic reset;
	logic request_valid;
	l2_op_t request_op;
	addr_word_t request_address;
	l2_line_t request_data;
	logic fill_valid;
	addr_word_t fill_address;
	l2_line_t fill_data;
	logic busy;
	logic response_valid;
	logic response_hit;
	l2_op_t response_op;
	addr_word_t response_address;
	l2_line_t response_data;
	logic evict_valid;
	addr_word_t evict_address;

	// Model cache state, per set and way
	int m_tag[`L2_SETS][`L2_WAYS];
	bit m_valid[`L2_SETS][`L2_WAYS];
	bit m_dirty[`L2_SETS][`L2_WAYS];
	l2_line_t m_data[`L2_SETS][`L2_WAYS];
	// Entry 0 least recent
	int m_order[`L2_SETS][`L2_WAYS];

	expect_t exp_q[$];
	expect_t seen;
	addr_word_t pool[POOL_SIZE];
	int cycle = 0;
	int ops_issued = 0;
	int checks = 0;
	int errors = 0;

	l2_cache_top i_dut(
		.clk(clk),
		.reset(reset),
		.request_valid(request_valid),
		.request_op(request_op),
		.request_address(request_address),
		.request_data(request_data),
		.fill_valid(fill_valid),
		.fill_address(fill_address),
		.fill_data(fill_data),
		.busy(busy),
		.response_valid(response_valid),
		.response_hit(response_hit),
		.response_op(response_op),
		.response_address(response_address),
		.response_data(response_data),
		.evict_valid(evict_valid),
		.evict_address(evict_address));

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk, posedge reset)
	begin
		if (reset)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	function automatic int find_way(input addr_word_t addr);
		int found;
		found = -1;
		for (int w = 0; w < `L2_WAYS; w++)
			if (m_valid[addr % `L2_SETS][w] && m_tag[addr % `L2_SETS][w] == addr / `L2_SETS)
				found = w;
		return found;
	endfunction

	// Move a way to most recent
	function automatic void touch_way(input int set, input int way);
		int pos;
		pos = 0;
		for (int i = 0; i < `L2_WAYS; i++)
			if (m_order[set][i] == way)
				pos = i;
		for (int i = pos; i < `L2_WAYS - 1; i++)
			m_order[set][i] = m_order[set][i + 1];
		m_order[set][`L2_WAYS - 1] = way;
	endfunction

	// Applies one operation to the model in program order and queues its result
	function automatic void reference_step(input bit is_fill, input bit op,
		input addr_word_t addr, input l2_line_t data, input int due);
		int set;
		int way;
		expect_t e;
		set = addr % `L2_SETS;
		e = '0;
		e.due = due;
		if (is_fill)
		begin
			way = m_order[set][0];
			// Only a dirty valid victim is reported
			if (m_valid[set][way] && m_dirty[set][way])
			begin
				e.is_evict = 1'b1;
				e.address = `L2_ADDR_BITS'(m_tag[set][way] * `L2_SETS + set);
				exp_q.push_back(e);
			end
			m_valid[set][way] = 1'b1;
			m_dirty[set][way] = 1'b0;
			m_tag[set][way] = addr / `L2_SETS;
			m_data[set][way] = data;
			touch_way(set, way);
		end
		else
		begin
			way = find_way(addr);
			e.op = op;
			e.address = addr;
			e.hit = way >= 0;
			if (way >= 0)
			begin
				if (op)
				begin
					m_data[set][way] = data;
					m_dirty[set][way] = 1'b1;
				end
				else
				begin
					e.check_data = 1'b1;
					e.data = m_data[set][way];
				end
				touch_way(set, way);
			end
			exp_q.push_back(e);
		end
	endfunction

	// Pool address that the model does not hold, so fills never duplicate a line
	function automatic addr_word_t absent_address();
		int idx;
		idx = $urandom % POOL_SIZE;
		while (find_way(pool[idx]) >= 0)
			idx = (idx + 1) % POOL_SIZE;
		return pool[idx];
	endfunction

	// Present for one cycle; a request with a fill checks the busy cycle
	task automatic issue(input bit do_req, input bit op, input addr_word_t addr,
		input l2_line_t data, input bit do_fill, input addr_word_t faddr, input l2_line_t fdata);
		request_valid = do_req;
		request_op = op ? op_store : op_load;
		request_address = addr;
		request_data = data;
		fill_valid = do_fill;
		fill_address = faddr;
		fill_data = fdata;
		// Fill goes first, a colliding request is held one cycle
		if (do_fill)
		begin
			reference_step(1'b1, 1'b0, faddr, fdata, cycle + 3);
			ops_issued++;
		end
		if (do_req)
		begin
			reference_step(1'b0, op, addr, data, cycle + (do_fill ? 4 : 3));
			ops_issued++;
		end
		@(posedge clk);
		#1;
		request_valid = 1'b0;
		fill_valid = 1'b0;
		if (do_req && do_fill)
		begin
			if (busy !== 1'b1)
			begin
				$display("ERR %0t: busy low in the cycle after a collision", $time);
				errors++;
			end
			@(posedge clk);
			#1;
			if (busy !== 1'b0)
			begin
				$display("ERR %0t: busy still high two cycles after a collision", $time);
				errors++;
			end
		end
	endtask

	task automatic load(input addr_word_t addr);
		issue(1'b1, 1'b0, addr, '0, 1'b0, '0, '0);
	endtask

	task automatic store(input addr_word_t addr, input l2_line_t data);
		issue(1'b1, 1'b1, addr, data, 1'b0, '0, '0);
	endtask

	task automatic fill(input addr_word_t addr, input l2_line_t data);
		issue(1'b0, 1'b0, '0, '0, 1'b1, addr, data);
	endtask

	// Wait until every expected output has been seen, then a few quiet cycles
	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4)
			@(posedge clk);
		#1;
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	// Outputs sampled mid-cycle and matched in order against the queue
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (response_valid || evict_valid)
			begin
				if (exp_q.size() == 0)
				begin
					$display("Unexpected output at %0t with nothing outstanding", $time);
					errors++;
				end
				else
				begin
					seen = exp_q.pop_front();
					checks++;
					if (seen.due != cycle)
					begin
						$display("ERR %0t: output in cycle %0d, expected %0d", $time, cycle, seen.due);
						errors++;
					end
					if (seen.is_evict)
					begin
						if (!evict_valid || response_valid)
						begin
							$display("ERR %0t: response seen where eviction expected", $time);
							errors++;
						end
						else if (evict_address != seen.address)
						begin
							$display("ERR %0t: evict address %h, expected %h", $time,
								evict_address, seen.address);
							errors++;
						end
					end
					else if (!response_valid || evict_valid)
					begin
						$display("ERR %0t: eviction seen where response expected", $time);
						errors++;
					end
					else if (response_hit != seen.hit || response_op != seen.op
						|| response_address != seen.address)
					begin
						$display("ERR %0t: response hit %b op %b address %h, expected %b %b %h",
							$time, response_hit, response_op, response_address,
							seen.hit, seen.op, seen.address);
						errors++;
					end
					else if (seen.check_data && response_data != seen.data)
					begin
						$display("ERR %0t: load data %h, expected %h", $time,
							response_data, seen.data);
						errors++;
					end
				end
			end
			else if (exp_q.size() != 0 && exp_q[0].due <= cycle)
			begin
				seen = exp_q.pop_front();
				$display("Missing %s for address %h, due in cycle %0d",
					seen.is_evict ? "eviction" : "response", seen.address, seen.due);
				errors++;
			end
		end
	end

	// Limit grows with the number of operations issued
	initial
	begin
		while (cycle <= ops_issued * 8 + 100)
			@(negedge clk);
		$display("Timeout after %0d cycles with %0d operations issued", cycle, ops_issued);
		errors++;
		finish_run();
	end

	initial
	begin
		int kind;
		addr_word_t addr;
		l2_line_t data;
		void'($urandom(32'h7c73_c822));
		reset = 1'b1;
		request_valid = 1'b0;
		request_op = op_load;
		request_address = '0;
		request_data = '0;
		fill_valid = 1'b0;
		fill_address = '0;
		fill_data = '0;
		for (int s = 0; s < `L2_SETS; s++)
			for (int w = 0; w < `L2_WAYS; w++)
			begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w] = 0;
				m_data[s][w] = '0;
				m_order[s][w] = w;
			end
		// Six distinct tags in each of sets 3 and 9, more than the ways
		for (int i = 0; i < POOL_SIZE; i++)
			pool[i] = `L2_ADDR_BITS'((16 + 19 * i) * `L2_SETS + (i < POOL_SIZE / 2 ? 3 : 9));
		repeat (4)
			@(posedge clk);
		#1;
		reset = 1'b0;

		// Cold cache
		for (int i = 0; i < 4; i++)
			load(pool[i]);
		drain();

		// Fill then load back to back, store hit then load, store miss then load
		fill(12'h121, 64'h0123_4567_89ab_cdef);
		load(12'h121);
		store(12'h121, 64'hfeed_f00d_0000_1111);
		load(12'h121);
		store(12'h231, 64'hdead_beef_dead_beef);
		load(12'h231);
		drain();

		// Five fills to set 5, with a hit on the first line before the fifth
		for (int i = 0; i < 4; i++)
			fill(addr_word_t'(12'h405 + 16 * i), {16'h5a5a, 48'(i)});
		load(12'h405);
		fill(12'h445, 64'h4444_4444_4444_4444);
		load(12'h415);
		load(12'h405);
		drain();

		// Dirty line in set 6 pushed out by the fourth of four new fills
		for (int i = 0; i < 4; i++)
			fill(addr_word_t'(12'h506 + 16 * i), {16'h6060, 48'(i)});
		store(12'h506, 64'h0d0d_0d0d_0d0d_0d0d);
		for (int i = 0; i < 4; i++)
			fill(addr_word_t'(12'h606 + 16 * i), {16'h6161, 48'(i)});
		drain();

		// Request and fill of the same line together
		issue(1'b1, 1'b0, 12'h707, '0, 1'b1, 12'h707, 64'h7777_0000_7777_0000);
		load(12'h707);
		drain();

		repeat (NUM_RANDOM)
		begin
			kind = $urandom % 10;
			addr = pool[$urandom % POOL_SIZE];
			data = {$urandom, $urandom};
			if (kind < 3)
				load(addr);
			else if (kind < 5)
				store(addr, data);
			else if (kind < 8)
				fill(absent_address(), data);
			else if (kind < 9)
				issue(1'b1, data[0], addr, data, 1'b1, absent_address(), {$urandom, $urandom});
			else
			begin
				@(posedge clk);
				#1;
			end
		end
		drain();
		finish_run();
	end
endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/l2_cache_pkg.sv
design/l2_cache_if.sv
design/sram_1r1w.sv
design/cache_lru.sv
design/l2_cache_arb.sv
design/l2_cache_tag.sv
design/l2_cache_read.sv
design/l2_cache_top.sv
bench/l2_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the L2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module l2_cache_tb -f sources.f
./obj_dir/Vl2_cache_tb | tee sim.log
if grep -q "^sim passed$" sim.log; then
	exit 0
else
	exit 1
fi
